// File: Makefile
# Verilator simulation of the NTM interpolation unit

TOP := ntm_interpolator_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: common/ntm_arith_pkg.sv
// Saturation helper expects exactly one guard bit above the word
`include "ntm_arith_settings.svh"
`default_nettype none

package ntm_arith_pkg;

  ////////////////////
  // Word and constants
  ////////////////////

  typedef logic signed [`FX_WIDTH-1:0] fx_word_t;

  localparam fx_word_t fx_max = {1'b0, {(`FX_WIDTH-1){1'b1}}};
  localparam fx_word_t fx_min = {1'b1, {(`FX_WIDTH-1){1'b0}}};
  localparam fx_word_t fx_one = fx_word_t'(1) <<< `FX_FRAC;

  ////////////////////
  // Bundles
  ////////////////////

  // Interpolation request as sampled with START
  typedef struct packed {
    fx_word_t gate;
    fx_word_t cur;
    fx_word_t prev;
  } interp_operands_t;

  // Multiplicand and multiplier of one product
  typedef struct packed {
    fx_word_t a;
    fx_word_t b;
  } mul_operands_t;

  // Saturated value with its overflow flag
  typedef struct packed {
    fx_word_t value;
    logic     overflow;
  } fx_product_t;

  // Clamp a value carrying one guard bit into the word range
  function automatic fx_product_t fx_sat_ext(input logic signed [`FX_WIDTH:0] wide);
    fx_product_t res;
    // Guard and sign bits disagree only when the value left the range
    res.overflow = wide[`FX_WIDTH] ^ wide[`FX_WIDTH-1];
    res.value    = res.overflow ? (wide[`FX_WIDTH] ? fx_min : fx_max) : wide[`FX_WIDTH-1:0];
    return res;
  endfunction

endpackage

`default_nettype wire

// File: common/ntm_arith_settings.svh
// Changing FX_WIDTH also requires FX_MUL_STEPS to follow it and FX_FRAC to stay below it
`ifndef NTM_ARITH_SETTINGS_SVH
`define NTM_ARITH_SETTINGS_SVH

`default_nettype none

////////////////////
// Fixed-point format
////////////////////

// Word width of every operand and result
`define FX_WIDTH 16

// Fraction bits, so 1.0 is 2**FX_FRAC
`define FX_FRAC 8

////////////////////
// Multiplier timing
////////////////////

// One multiplier bit per step
`define FX_MUL_STEPS `FX_WIDTH

`default_nettype wire

`endif

// File: dv/interp_checker.sv
// Assumes a single operation in flight and READY FX_MUL_STEPS+2 cycles after each accepted START
`timescale 1ns/1ps
`include "ntm_arith_settings.svh"
`default_nettype none

module interp_checker import ntm_arith_pkg::*; (
  input  wire               CLK,
  input  wire               RST,
  input  wire               START,
  input  interp_operands_t  operands,
  input  wire               READY,
  input  fx_word_t          result,
  input  wire               overflow,
  input  wire [2:0]         test_id,
  input  wire               tests_done,
  input  wire [31:0]        ready_timeouts,
  output logic [31:0]       error_count
);

  localparam int LATENCY = `FX_MUL_STEPS + 2;

  int unsigned        cycle;
  int unsigned        value_errors;
  int unsigned        protocol_errors;
  logic               busy;
  logic               op_closed;
  logic               reset_checked;
  logic               reported;

  // Pending operations with the oldest first
  int unsigned        due_q[$];
  logic [`FX_WIDTH:0] exp_q[$];
  logic [2:0]         id_q[$];

  function automatic string test_label(input logic [2:0] id);
    case (id)
      3'd1: return "directed_gate";
      3'd2: return "random_unit_gate";
      3'd3: return "extrapolate";
      3'd4: return "signs_truncation";
      3'd5: return "busy_start";
      default: return "unknown";
    endcase
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Clamp to the word range with the low bit flagging a clamp
  function automatic logic [`FX_WIDTH:0] clamp_word(input longint v);
    longint lo;
    longint hi;
    lo = -(longint'(1) <<< (`FX_WIDTH - 1));
    hi = (longint'(1) <<< (`FX_WIDTH - 1)) - 1;
    if (v > hi) return {fx_word_t'(hi), 1'b1};
    if (v < lo) return {fx_word_t'(lo), 1'b1};
    return {fx_word_t'(v), 1'b0};
  endfunction

  // g*cur + (1-g)*prev with each product floored then clamped
  function automatic logic [`FX_WIDTH:0] interp_ref(input longint g, input longint c,
                                                    input longint p);
    logic [`FX_WIDTH:0] comp;
    logic [`FX_WIDTH:0] cur_p;
    logic [`FX_WIDTH:0] prev_p;
    logic [`FX_WIDTH:0] sum;
    longint             one;
    one    = longint'(1) <<< `FX_FRAC;
    comp   = clamp_word(one - g);
    cur_p  = clamp_word((g * c) >>> `FX_FRAC);
    prev_p = clamp_word((longint'($signed(comp[`FX_WIDTH:1])) * p) >>> `FX_FRAC);
    sum    = clamp_word(longint'($signed(cur_p[`FX_WIDTH:1]))
                      + longint'($signed(prev_p[`FX_WIDTH:1])));
    return {sum[`FX_WIDTH:1], comp[0] | cur_p[0] | prev_p[0] | sum[0]};
  endfunction

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge CLK) begin
    if (RST) begin
      cycle           = 0;
      busy            = 1'b0;
      reset_checked   = 1'b0;
      reported        = 1'b0;
      value_errors    = 0;
      protocol_errors = 0;
      due_q.delete();
      exp_q.delete();
      id_q.delete();
    end else begin
      cycle     = cycle + 1;
      op_closed = 1'b0;
      // First cycle out of reset
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (READY || overflow || result != '0) begin
          value_errors++;
          $display("mismatch reset_state: expected READY 0 result 0 overflow 0, %s",
                   $sformatf("actual READY %0b result %0d overflow %0b",
                             READY, result, overflow));
        end
      end
      if (READY) begin
        if (due_q.size() == 0) begin
          protocol_errors++;
          $display("error: READY pulsed at cycle %0d with no operation pending", cycle);
        end else begin
          if (due_q[0] != cycle) begin
            protocol_errors++;
            $display("error: %s READY came at cycle %0d but was due at cycle %0d",
                     test_label(id_q[0]), cycle, due_q[0]);
          end
          if ({result, overflow} !== exp_q[0]) begin
            value_errors++;
            $display("mismatch %s: expected result %0d overflow %0b, %s",
                     test_label(id_q[0]), $signed(exp_q[0][`FX_WIDTH:1]), exp_q[0][0],
                     $sformatf("actual result %0d overflow %0b", result, overflow));
          end
          void'(due_q.pop_front());
          void'(exp_q.pop_front());
          void'(id_q.pop_front());
          op_closed = 1'b1;
        end
      end else if (due_q.size() != 0 && cycle > due_q[0]) begin
        protocol_errors++;
        $display("error: %s never got READY by cycle %0d", test_label(id_q[0]), due_q[0]);
        void'(due_q.pop_front());
        void'(exp_q.pop_front());
        void'(id_q.pop_front());
        op_closed = 1'b1;
      end
      // Busy still covers the READY cycle, so a START there is dropped
      if (START && !busy) begin
        due_q.push_back(cycle + LATENCY);
        exp_q.push_back(interp_ref(operands.gate, operands.cur, operands.prev));
        id_q.push_back(test_id);
        busy = 1'b1;
      end
      if (op_closed) busy = 1'b0;
      if (tests_done && !reported) begin
        reported = 1'b1;
        if (due_q.size() != 0) begin
          protocol_errors += due_q.size();
          $display("error: %0d operations still waiting for READY at the end", due_q.size());
        end
        $display("checker: %0d value mismatches, %0d protocol errors, %0d READY timeouts",
                 value_errors, protocol_errors, ready_timeouts);
      end
    end
    error_count = value_errors + protocol_errors + ready_timeouts;
  end

endmodule

`default_nettype wire

// File: dv/ntm_interpolator_tb.sv
// Issues one request at a time and overlaps requests only in the busy START cases
`timescale 1ns/1ps
`include "ntm_arith_settings.svh"
`default_nettype none

module ntm_interpolator_tb import ntm_arith_pkg::*; ();

  localparam int N_DIRECTED      = 4;
  localparam int N_RANDOM        = 40;
  localparam int N_EXTRAP        = 16;
  localparam int N_SIGNS         = 16;
  localparam int N_BUSY          = 2;
  localparam int N_TESTS         = N_DIRECTED + N_RANDOM + N_EXTRAP + N_SIGNS + N_BUSY;
  localparam int WATCHDOG_CYCLES = N_TESTS * 20 + 50;
  localparam int READY_WAIT      = `FX_MUL_STEPS + 10;

  logic             CLK;
  logic             RST;
  logic             START;
  interp_operands_t operands;
  logic             READY;
  fx_word_t         result;
  logic             overflow;
  logic [2:0]       test_id;
  logic             tests_done;
  logic [31:0]      error_count;
  logic [31:0]      lfsr_state;
  int               wait_errors;

  ntm_interpolator dut_i (
    .CLK      (CLK),
    .RST      (RST),
    .START    (START),
    .operands (operands),
    .READY    (READY),
    .result   (result),
    .overflow (overflow)
  );

  interp_checker checker_i (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .operands       (operands),
    .READY          (READY),
    .result         (result),
    .overflow       (overflow),
    .test_id        (test_id),
    .tests_done     (tests_done),
    .ready_timeouts (wait_errors),
    .error_count    (error_count)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic wait_ready();
    int   n;
    logic ready_seen;
    n          = 0;
    ready_seen = 1'b0;
    while (!ready_seen && n < READY_WAIT) begin
      @(posedge CLK);
      n++;
      ready_seen = READY;
    end
    if (!ready_seen) begin
      wait_errors++;
      $display("error: no READY within %0d cycles of test %0d", READY_WAIT, test_id);
    end
  endtask

  task automatic run_op(input logic [2:0] id, input fx_word_t g, input fx_word_t c,
                        input fx_word_t p);
    @(posedge CLK);
    START    <= 1'b1;
    operands <= {g, c, p};
    test_id  <= id;
    @(posedge CLK);
    START <= 1'b0;
    wait_ready();
  endtask

  // Second START lands while the first request is still busy
  task automatic run_busy_op(input fx_word_t g, input fx_word_t c, input fx_word_t p,
                             input int delay, input fx_word_t g2, input fx_word_t c2,
                             input fx_word_t p2);
    @(posedge CLK);
    START    <= 1'b1;
    operands <= {g, c, p};
    test_id  <= 3'd5;
    @(posedge CLK);
    START <= 1'b0;
    repeat (delay) @(posedge CLK);
    START    <= 1'b1;
    operands <= {g2, c2, p2};
    @(posedge CLK);
    START <= 1'b0;
    wait_ready();
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [15:0] gb;
    logic [15:0] cb;
    logic [15:0] pb;
    RST         = 1'b1;
    START       = 1'b0;
    operands    = '0;
    test_id     = '0;
    tests_done  = 1'b0;
    wait_errors = 0;
    lfsr_state  = 32'hf336f028;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    // Let the checker see the idle outputs
    repeat (2) @(posedge CLK);

    // Gate 0, one, and one half
    run_op(3'd1, 16'sh0000, 16'sh0340, -16'sh0125);
    run_op(3'd1, 16'sh0100, -16'sh0277, 16'sh0510);
    run_op(3'd1, 16'sh0080, 16'sh0301, 16'sh0100);
    run_op(3'd1, 16'sh0080, -16'sh0101, 16'sh0002);

    // Gate within 0 to one
    for (int i = 0; i < N_RANDOM; i++) begin
      draw_bits(9, gb);
      draw_bits(16, cb);
      draw_bits(16, pb);
      run_op(3'd2, fx_word_t'(gb > 16'd256 ? gb - 16'd256 : gb), cb, pb);
    end

    // Extrapolation and saturation
    run_op(3'd3, fx_max, fx_max, fx_max);
    run_op(3'd3, fx_min, 16'sh03e8, fx_max);
    run_op(3'd3, 16'sh0800, 16'sh4000, -16'sh4000);
    run_op(3'd3, -16'sh0800, 16'sh2000, 16'sh7000);
    for (int i = 0; i < N_EXTRAP - 4; i++) begin
      draw_bits(16, gb);
      draw_bits(16, cb);
      draw_bits(16, pb);
      run_op(3'd3, gb, cb, pb);
    end

    // Negative operands with small gates
    run_op(3'd4, 16'sh0001, -16'sh0001, -16'sh0003);
    run_op(3'd4, 16'sh0003, -16'sh0055, -16'sh0101);
    run_op(3'd4, 16'sh0000, -16'sh0001, -16'sh7fff);
    run_op(3'd4, 16'sh0010, fx_min, -16'sh0001);
    for (int i = 0; i < N_SIGNS - 4; i++) begin
      draw_bits(6, gb);
      draw_bits(15, cb);
      draw_bits(15, pb);
      run_op(3'd4, gb, {1'b1, cb[14:0]}, {1'b1, pb[14:0]});
    end

    // START while busy early and late in the operation
    run_busy_op(16'sh0040, 16'sh1200, 16'sh0f00, 1, 16'sh0100, 16'sh7fff, 16'sh7fff);
    run_busy_op(-16'sh0200, 16'sh0333, -16'sh0444, 15, fx_min, fx_min, fx_min);
    // Window for a stray READY
    repeat (24) @(posedge CLK);

    @(posedge CLK);
    tests_done <= 1'b1;
    // Checker closes its counts on this edge
    @(posedge CLK);
    @(negedge CLK);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: fixed_multiplier/fixed_multiplier.sv
// Operands are sampled only in the START cycle and START is ignored while a product runs
`timescale 1ns/1ps
`include "ntm_arith_settings.svh"
`default_nettype none

module fixed_multiplier import ntm_arith_pkg::*; (
  input  wire            CLK,
  input  wire            RST,
  input  wire            START,
  input  mul_operands_t  operands,
  output logic           READY,
  output fx_product_t    product
);

  localparam int W  = `FX_WIDTH;
  localparam int PW = 2 * `FX_WIDTH;
  localparam int CW = $clog2(`FX_MUL_STEPS + 1);

  // Two-state controller
  localparam logic IDLE_STATE = 1'b0;
  localparam logic RUN_STATE  = 1'b1;

  ////////////////////
  // Signals
  ////////////////////

  logic          state_q;
  logic [CW-1:0] step_q;

  // Shift-add datapath on magnitudes
  logic          neg_q;
  logic [PW-1:0] acc_q;
  logic [PW-1:0] mcand_q;
  logic [W-1:0]  mplier_q;

  logic [W-1:0]        mag_a;
  logic [W-1:0]        mag_b;
  logic [PW-1:0]       acc_next;
  logic signed [PW:0]  prod_signed;
  logic signed [PW:0]  prod_shifted;
  fx_product_t         sat_prod;

  logic start_ok;
  logic last_step;

  assign start_ok  = (state_q == IDLE_STATE) && START;
  assign last_step = (state_q == RUN_STATE) && (step_q == CW'(`FX_MUL_STEPS - 1));

  ////////////////////
  // Combinational datapath
  ////////////////////

  always_comb begin
    // Magnitude of fx_min is still representable unsigned
    mag_a = operands.a[W-1] ? (~operands.a + 1'b1) : operands.a;
    mag_b = operands.b[W-1] ? (~operands.b + 1'b1) : operands.b;

    // Partial product for the current multiplier bit
    acc_next = acc_q + (mplier_q[0] ? mcand_q : '0);

    // Restore sign, then arithmetic shift truncates toward minus infinity
    prod_signed  = neg_q ? -$signed({1'b0, acc_next}) : $signed({1'b0, acc_next});
    prod_shifted = prod_signed >>> `FX_FRAC;

    // Clamp to the word range
    if (prod_shifted > (PW+1)'(fx_max)) begin
      sat_prod.value    = fx_max;
      sat_prod.overflow = 1'b1;
    end else if (prod_shifted < (PW+1)'(fx_min)) begin
      sat_prod.value    = fx_min;
      sat_prod.overflow = 1'b1;
    end else begin
      sat_prod.value    = prod_shifted[W-1:0];
      sat_prod.overflow = 1'b0;
    end
  end

  ////////////////////
  // Datapath registers
  ////////////////////

  always_ff @(posedge CLK) begin
    if (start_ok) begin
      // Bit 0 is taken while capturing
      acc_q    <= mag_b[0] ? PW'(mag_a) : '0;
      mcand_q  <= PW'(mag_a) << 1;
      mplier_q <= mag_b >> 1;
      neg_q    <= operands.a[W-1] ^ operands.b[W-1];
    end else if (state_q == RUN_STATE) begin
      acc_q    <= acc_next;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  ////////////////////
  // Controller
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= IDLE_STATE;
      step_q  <= '0;
      READY   <= 1'b0;
      product <= '0;
    end else begin
      case (state_q)
        IDLE_STATE: begin
          READY <= 1'b0;
          if (START) begin
            state_q <= RUN_STATE;
            step_q  <= CW'(1);
          end
        end
        RUN_STATE: begin
          if (last_step) begin
            // Final bit folded in, result out
            product <= sat_prod;
            READY   <= 1'b1;
            state_q <= IDLE_STATE;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/gate_split.sv
// Holds one request at a time and drops any START that arrives before done
`timescale 1ns/1ps
`include "ntm_arith_settings.svh"
`default_nettype none

module gate_split import ntm_arith_pkg::*; (
  input  wire               CLK,
  input  wire               RST,
  input  wire               START,
  input  interp_operands_t  operands,
  input  wire               done,
  output logic              mul_start,
  output mul_operands_t     cur_term,
  output mul_operands_t     prev_term,
  output logic              comp_overflow
);

  ////////////////////
  // Signals
  ////////////////////

  logic busy_q;
  logic accept;

  // Latched request and complement gate
  interp_operands_t ops_q;
  fx_word_t         comp_q;

  logic signed [`FX_WIDTH:0] comp_wide;
  fx_product_t               comp_sat;

  assign accept = START && !busy_q;

  // One minus gate with a guard bit
  assign comp_wide = {fx_one[`FX_WIDTH-1], fx_one} - {operands.gate[`FX_WIDTH-1], operands.gate};
  assign comp_sat  = fx_sat_ext(comp_wide);

  ////////////////////
  // Request latch
  ////////////////////

  always_ff @(posedge CLK) begin
    if (accept) begin
      ops_q  <= operands;
      comp_q <= comp_sat.value;
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q        <= 1'b0;
      mul_start     <= 1'b0;
      comp_overflow <= 1'b0;
    end else begin
      // Launch both products the cycle after acceptance
      mul_start <= accept;
      if (accept) begin
        busy_q        <= 1'b1;
        comp_overflow <= comp_sat.overflow;
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // gate times cur, complement times prev
  assign cur_term.a  = ops_q.gate;
  assign cur_term.b  = ops_q.cur;
  assign prev_term.a = comp_q;
  assign prev_term.b = ops_q.prev;

endmodule

`default_nettype wire

// File: hdl/interp_combiner.sv
// Pairs one done pulse from each multiplier per operation and expects products held until then
`timescale 1ns/1ps
`include "ntm_arith_settings.svh"
`default_nettype none

module interp_combiner import ntm_arith_pkg::*; (
  input  wire          CLK,
  input  wire          RST,
  input  wire          cur_done,
  input  wire          prev_done,
  input  fx_product_t  cur_product,
  input  fx_product_t  prev_product,
  input  wire          comp_overflow,
  output logic         READY,
  output fx_word_t     result,
  output logic         overflow
);

  ////////////////////
  // Signals
  ////////////////////

  // Done pulses seen in earlier cycles
  logic cur_seen_q;
  logic prev_seen_q;
  logic both_done;

  logic signed [`FX_WIDTH:0] sum_wide;
  fx_product_t               sum_sat;
  logic                      any_ovf;

  assign both_done = (cur_done || cur_seen_q) && (prev_done || prev_seen_q);

  // Sum in one extra bit, then clamp
  assign sum_wide = {cur_product.value[`FX_WIDTH-1], cur_product.value}
                  + {prev_product.value[`FX_WIDTH-1], prev_product.value};
  assign sum_sat  = fx_sat_ext(sum_wide);

  // Any saturation along the path marks the result
  assign any_ovf = comp_overflow || cur_product.overflow || prev_product.overflow
                || sum_sat.overflow;

  ////////////////////
  // Output stage
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cur_seen_q  <= 1'b0;
      prev_seen_q <= 1'b0;
      READY       <= 1'b0;
      result      <= '0;
      overflow    <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (both_done) begin
        result      <= sum_sat.value;
        overflow    <= any_ovf;
        READY       <= 1'b1;
        cur_seen_q  <= 1'b0;
        prev_seen_q <= 1'b0;
      end else begin
        // Wait for the slower product
        if (cur_done) cur_seen_q <= 1'b1;
        if (prev_done) prev_seen_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/ntm_interpolator.sv
// READY follows an accepted START by FX_MUL_STEPS+2 cycles and result holds until the next READY
`timescale 1ns/1ps
`default_nettype none

module ntm_interpolator import ntm_arith_pkg::*; (
  input  wire               CLK,
  input  wire               RST,
  input  wire               START,
  input  interp_operands_t  operands,
  output logic              READY,
  output fx_word_t          result,
  output logic              overflow
);

  ////////////////////
  // Internal nets
  ////////////////////

  logic          mul_start;
  mul_operands_t cur_term;
  mul_operands_t prev_term;
  logic          comp_overflow;

  logic          cur_done;
  logic          prev_done;
  fx_product_t   cur_product;
  fx_product_t   prev_product;

  // Operand latch and complement gate
  gate_split split_i (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .operands      (operands),
    .done          (READY),
    .mul_start     (mul_start),
    .cur_term      (cur_term),
    .prev_term     (prev_term),
    .comp_overflow (comp_overflow)
  );

  // g times cur
  fixed_multiplier cur_mul_i (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mul_start),
    .operands (cur_term),
    .READY    (cur_done),
    .product  (cur_product)
  );

  // (1-g) times prev
  fixed_multiplier prev_mul_i (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mul_start),
    .operands (prev_term),
    .READY    (prev_done),
    .product  (prev_product)
  );

  // Final sum and result register
  interp_combiner combine_i (
    .CLK           (CLK),
    .RST           (RST),
    .cur_done      (cur_done),
    .prev_done     (prev_done),
    .cur_product   (cur_product),
    .prev_product  (prev_product),
    .comp_overflow (comp_overflow),
    .READY         (READY),
    .result        (result),
    .overflow      (overflow)
  );

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/ntm_arith_pkg.sv
fixed_multiplier/fixed_multiplier.sv
hdl/gate_split.sv
hdl/interp_combiner.sv
hdl/ntm_interpolator.sv
dv/interp_checker.sv
dv/ntm_interpolator_tb.sv
